// File: Makefile
# Verilator build and run for the tensor-matrix product testbench
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_tensor_product
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Status follows the pass line in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+.
tensor_product_pkg.sv
scalar_op_if.sv
scalar_int_adder.sv
scalar_int_multiplier.sv
tensor_matrix_product.sv
tensor_product_top.sv
tb_clock_gen.sv
tb_tensor_product.sv

// File: scalar_int_adder.sv
/* Registered integer adder, wrap-around on the element width
   Ready follows start by one cycle
   Result holds until the next start */
`timescale 1ns/100ps

module scalar_int_adder (
  input logic CLK,
  input logic RST,

  scalar_op_if.unit bus
);

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  // One ready pulse per start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.start;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Sum kept on the element width, carry out dropped
  always_ff @(posedge CLK) begin
    if (bus.start) begin
      bus.result <= bus.operand_a + bus.operand_b;
    end
  end

  // Controller never issues back-to-back requests
  assert property (@(posedge CLK) disable iff (RST)
    bus.ready |=> !bus.ready);

endmodule

// File: scalar_int_multiplier.sv
/* Registered signed integer multiplier
   Keeps only the low element-width bits of the product
   Ready follows start by one cycle, result holds until the next start */
`timescale 1ns/100ps

module scalar_int_multiplier (
  input logic CLK,
  input logic RST,

  scalar_op_if.unit bus
);

  //////////////////////////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.start;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  // Product sized by the element-width target
  // Low bits are the same for signed or unsigned operands
  always_ff @(posedge CLK) begin
    if (bus.start) begin
      bus.result <= bus.operand_a * bus.operand_b;
    end
  end

  // Controller relies on a fixed one-cycle latency
  assert property (@(posedge CLK) disable iff (RST)
    bus.start |=> bus.ready);

endmodule

// File: scalar_op_if.sv
/* Start/ready link between the controller and one scalar unit
   Start is a one-cycle pulse with operands valid in that cycle
   Ready is a one-cycle pulse with result valid in that cycle */
`timescale 1ns/100ps

interface scalar_op_if;

  // Request from the controller
  logic                      start;
  tensor_product_pkg::data_t operand_a;
  tensor_product_pkg::data_t operand_b;

  // Response from the unit
  logic                      ready;
  tensor_product_pkg::data_t result;

  modport controller (
    output start, operand_a, operand_b,
    input  ready, result
  );

  modport unit (
    input  start, operand_a, operand_b,
    output ready, result
  );

endinterface

// File: tb_clock_gen.sv
/* Clock and reset for the testbench
   100 ns period, reset high for the first 8 rising edges */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic CLK,
  output logic RST
);

  localparam int half_period = 50;

  initial begin
    CLK = 1'b0;
    forever #half_period CLK = ~CLK;
  end

  // Release away from the clock edge
  initial begin
    RST = 1'b1;
    repeat (8) @(posedge CLK);
    #10 RST = 1'b0;
  end

endmodule

// File: tb_tensor_product.sv
/* Testbench for the tensor-matrix product
   Inputs change 10 ns after each rising edge, outputs checked on falling edges
   Expected C comes from stream-ordered copies of A and B */
`timescale 1ns/100ps
`include "tensor_product_config.svh"

module tb_tensor_product;

  localparam int max_dim = `TMP_MAX_DIM;
  localparam int prod_w = 2 * `TMP_DATA_WIDTH;
  localparam int run_timeout = 5000;

  logic                      CLK;
  logic                      RST;
  logic                      start;
  logic                      ready;
  tensor_product_pkg::dim_t  size_i;
  tensor_product_pkg::dim_t  size_j;
  tensor_product_pkg::dim_t  size_k;
  tensor_product_pkg::dim_t  size_l;
  tensor_product_pkg::data_t data_a_in;
  logic                      data_a_enable;
  tensor_product_pkg::data_t data_b_in;
  logic                      data_b_enable;
  tensor_product_pkg::data_t data_out;
  logic                      data_out_enable;
  logic                      data_out_last;

  // Copies of A and B, packed in stream order
  tensor_product_pkg::data_t a_tb [max_dim * max_dim * max_dim];
  tensor_product_pkg::data_t b_tb [max_dim * max_dim];
  tensor_product_pkg::data_t exp_q [$];
  tensor_product_pkg::data_t exp_val;

  int seed = 32'h8d15;
  int run_errors = 0;
  int check_errors = 0;
  int timeouts = 0;
  int beats = 0;
  bit last_seen = 1'b0;
  bit last_exp;

  tb_clock_gen clock_gen_i (
    .CLK(CLK),
    .RST(RST)
  );

  tensor_product_top tensor_product_top_i (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ready          (ready),
    .size_i         (size_i),
    .size_j         (size_j),
    .size_k         (size_k),
    .size_l         (size_l),
    .data_a_in      (data_a_in),
    .data_a_enable  (data_a_enable),
    .data_b_in      (data_b_in),
    .data_b_enable  (data_b_enable),
    .data_out       (data_out),
    .data_out_enable(data_out_enable),
    .data_out_last  (data_out_last)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Products keep their low bits, sums wrap on the element width
  function automatic tensor_product_pkg::data_t expected_element(
    input int i, input int j, input int l, input int nj, input int nk, input int nl);
    tensor_product_pkg::data_t sum;
    logic signed [prod_w-1:0]  prod;
    sum = '0;
    for (int k = 0; k < nk; k++) begin
      prod = prod_w'(a_tb[(i * nj + j) * nk + k]) * prod_w'(b_tb[k * nl + l]);
      sum = sum + prod[`TMP_DATA_WIDTH-1:0];
    end
    return sum;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    @(posedge CLK);
    #10;
  endtask

  // A elements first, then B, optional idle gaps before each one
  task automatic load_streams(input int na, input int nb, input bit gaps);
    int gap;
    for (int n = 0; n < na + nb; n++) begin
      gap = gaps ? ($random(seed) & 3) : 0;
      data_a_enable = 1'b0;
      data_b_enable = 1'b0;
      repeat (gap) step_cycle();
      if (n < na) begin
        data_a_in = a_tb[n];
        data_a_enable = 1'b1;
      end else begin
        data_b_in = b_tb[n - na];
        data_b_enable = 1'b1;
      end
      step_cycle();
    end
    data_a_enable = 1'b0;
    data_b_enable = 1'b0;
  endtask

  // START and junk writes while the FSM is busy computing
  task automatic stray_inputs();
    repeat (3) step_cycle();
    start = 1'b1;
    data_a_in = '1;
    data_b_in = '1;
    data_a_enable = 1'b1;
    data_b_enable = 1'b1;
    step_cycle();
    start = 1'b0;
    repeat (2) step_cycle();
    data_a_enable = 1'b0;
    data_b_enable = 1'b0;
  endtask

  task automatic run_product(input int ni, input int nj, input int nk, input int nl,
                             input bit random_data, input bit gaps, input bit disturb);
    int tmp;
    int waited;
    for (int n = 0; n < ni * nj * nk; n++) begin
      tmp = random_data ? $random(seed) : n % 7 + 1;
      a_tb[n] = tmp[`TMP_DATA_WIDTH-1:0];
    end
    for (int n = 0; n < nk * nl; n++) begin
      tmp = random_data ? $random(seed) : n % 5 + 2;
      b_tb[n] = tmp[`TMP_DATA_WIDTH-1:0];
    end
    // Output order is l fastest, then j, then i
    for (int i = 0; i < ni; i++) begin
      for (int j = 0; j < nj; j++) begin
        for (int l = 0; l < nl; l++) begin
          exp_q.push_back(expected_element(i, j, l, nj, nk, nl));
        end
      end
    end
    step_cycle();
    size_i = ni[`TMP_DIM_WIDTH-1:0];
    size_j = nj[`TMP_DIM_WIDTH-1:0];
    size_k = nk[`TMP_DIM_WIDTH-1:0];
    size_l = nl[`TMP_DIM_WIDTH-1:0];
    start = 1'b1;
    step_cycle();
    start = 1'b0;
    load_streams(ni * nj * nk, nk * nl, gaps);
    if (disturb) begin
      stray_inputs();
    end
    waited = 0;
    @(negedge CLK);
    while (ready !== 1'b1 && waited < run_timeout) begin
      @(negedge CLK);
      waited++;
    end
    if (ready !== 1'b1) begin
      $display("Timed out after %0d cycles waiting for ready", waited);
      timeouts++;
    end else if (exp_q.size() != 0) begin
      $display("Run %0dx%0dx%0d by %0dx%0d ended with %0d outputs missing",
               ni, nj, nk, nk, nl, exp_q.size());
      run_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output checker
  //////////////////////////////////////////////////////////////////////

  // Ready must pulse exactly on the cycle after the last beat
  always @(negedge CLK) begin
    if (!RST) begin
      if (ready !== last_seen) begin
        $display("ERROR t=%0t ready expected %0b got %0b", $time, last_seen, ready);
        check_errors++;
      end
      last_seen = data_out_enable && data_out_last;
      if (data_out_enable) begin
        if (exp_q.size() == 0) begin
          $display("Output beat at %0t with no element pending", $time);
          check_errors++;
        end else begin
          exp_val = exp_q.pop_front();
          last_exp = (exp_q.size() == 0);
          beats++;
          if (data_out !== exp_val) begin
            $display("ERROR t=%0t data_out expected %0d got %0d", $time, exp_val, data_out);
            check_errors++;
          end
          if (data_out_last !== last_exp) begin
            $display("ERROR t=%0t data_out_last expected %0b got %0b",
                     $time, last_exp, data_out_last);
            check_errors++;
          end
        end
      end else if (data_out_last) begin
        $display("data_out_last high at %0t without data_out_enable", $time);
        check_errors++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int waited;
    start = 1'b0;
    size_i = '0;
    size_j = '0;
    size_k = '0;
    size_l = '0;
    data_a_in = '0;
    data_a_enable = 1'b0;
    data_b_in = '0;
    data_b_enable = 1'b0;
    waited = 0;
    while (RST !== 1'b0 && waited < 20) begin
      @(negedge CLK);
      waited++;
    end
    if (RST !== 1'b0) begin
      $display("Reset never released after %0d cycles", waited);
      timeouts++;
    end
    // Quiet cycles, any ready or output beat here is flagged
    repeat (10) @(negedge CLK);
    if (timeouts == 0) run_product(2, 2, 2, 2, 1'b0, 1'b0, 1'b0);
    if (timeouts == 0) run_product(4, 4, 4, 4, 1'b1, 1'b0, 1'b0);
    if (timeouts == 0) run_product(1, 3, 2, 4, 1'b1, 1'b1, 1'b0);
    if (timeouts == 0) run_product(2, 2, 2, 2, 1'b1, 1'b0, 1'b1);
    // Second run from idle, sum must start from zero again
    if (timeouts == 0) run_product(3, 2, 3, 2, 1'b1, 1'b1, 1'b0);
    repeat (3) @(negedge CLK);
    $display("Beats checked: %0d, errors: %0d, timeouts: %0d",
             beats, run_errors + check_errors, timeouts);
    if (run_errors + check_errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: tensor_matrix_product.sv
/* Controller for C[i][j][l] = sum over k of A[i][j][k] * B[k][l]
   Sizes latched on start, each must be 1..TMP_MAX_DIM
   A streams k fastest then j then i, B streams l fastest then k
   C leaves l fastest then j then i, with no back-pressure */
`timescale 1ns/100ps
`include "tensor_product_config.svh"

module tensor_matrix_product (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  output logic                      ready,
  input  tensor_product_pkg::dim_t  size_i,
  input  tensor_product_pkg::dim_t  size_j,
  input  tensor_product_pkg::dim_t  size_k,
  input  tensor_product_pkg::dim_t  size_l,
  input  tensor_product_pkg::data_t data_a_in,
  input  logic                      data_a_enable,
  input  tensor_product_pkg::data_t data_b_in,
  input  logic                      data_b_enable,
  output tensor_product_pkg::data_t data_out,
  output logic                      data_out_enable,
  output logic                      data_out_last,

  scalar_op_if.controller mul,
  scalar_op_if.controller add
);

  localparam int max_dim = `TMP_MAX_DIM;
  localparam int a_addr_w = $clog2(max_dim * max_dim * max_dim);
  localparam int b_addr_w = $clog2(max_dim * max_dim);
  localparam tensor_product_pkg::dim_t dim_one = 1;

  //////////////////////////////////////////////////////////////////////
  // State and storage
  //////////////////////////////////////////////////////////////////////

  tensor_product_pkg::tmp_state_t state;

  // Latched sizes
  tensor_product_pkg::dim_t dim_i;
  tensor_product_pkg::dim_t dim_j;
  tensor_product_pkg::dim_t dim_k;
  tensor_product_pkg::dim_t dim_l;

  // Loop counters, shared by loading and compute
  tensor_product_pkg::dim_t cnt_i;
  tensor_product_pkg::dim_t cnt_j;
  tensor_product_pkg::dim_t cnt_k;
  tensor_product_pkg::dim_t cnt_l;

  tensor_product_pkg::data_t a_mem [max_dim * max_dim * max_dim];
  tensor_product_pkg::data_t b_mem [max_dim * max_dim];
  tensor_product_pkg::data_t acc;

  logic [a_addr_w-1:0] a_addr;
  logic [b_addr_w-1:0] b_addr;
  logic                mul_wait;
  logic                add_wait;
  logic                i_last;
  logic                j_last;
  logic                k_last;
  logic                l_last;

  // Fixed-stride layout, A as [i][j][k] and B as [k][l]
  assign a_addr = a_addr_w'((int'(cnt_i) * max_dim + int'(cnt_j)) * max_dim + int'(cnt_k));
  assign b_addr = b_addr_w'(int'(cnt_k) * max_dim + int'(cnt_l));

  assign i_last = (cnt_i == dim_i - dim_one);
  assign j_last = (cnt_j == dim_j - dim_one);
  assign k_last = (cnt_k == dim_k - dim_one);
  assign l_last = (cnt_l == dim_l - dim_one);

  // Multiply step, start on the first cycle of multiply only
  assign mul.start     = (state == tensor_product_pkg::multiply) && !mul_wait;
  assign mul.operand_a = a_mem[a_addr];
  assign mul.operand_b = b_mem[b_addr];

  // Add step, product plus running sum
  assign add.start     = (state == tensor_product_pkg::accumulate) && !add_wait;
  assign add.operand_a = mul.result;
  assign add.operand_b = acc;

  // Stream writes
  always_ff @(posedge CLK) begin
    if (state == tensor_product_pkg::load_a && data_a_enable) begin
      a_mem[a_addr] <= data_a_in;
    end
    if (state == tensor_product_pkg::load_b && data_b_enable) begin
      b_mem[b_addr] <= data_b_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= tensor_product_pkg::idle;
      ready           <= 1'b0;
      data_out        <= '0;
      data_out_enable <= 1'b0;
      data_out_last   <= 1'b0;
      mul_wait        <= 1'b0;
      add_wait        <= 1'b0;
      acc             <= '0;
      dim_i           <= '0;
      dim_j           <= '0;
      dim_k           <= '0;
      dim_l           <= '0;
      cnt_i           <= '0;
      cnt_j           <= '0;
      cnt_k           <= '0;
      cnt_l           <= '0;
    end else begin
      // Pulses default low
      ready           <= 1'b0;
      data_out_enable <= 1'b0;
      data_out_last   <= 1'b0;
      case (state)
        tensor_product_pkg::idle: begin
          if (start) begin
            dim_i <= size_i;
            dim_j <= size_j;
            dim_k <= size_k;
            dim_l <= size_l;
            cnt_i <= '0;
            cnt_j <= '0;
            cnt_k <= '0;
            cnt_l <= '0;
            acc   <= '0;
            state <= tensor_product_pkg::load_a;
          end
        end
        // A walks k, then j, then i
        tensor_product_pkg::load_a: begin
          if (data_a_enable) begin
            if (!k_last) begin
              cnt_k <= cnt_k + dim_one;
            end else begin
              cnt_k <= '0;
              if (!j_last) begin
                cnt_j <= cnt_j + dim_one;
              end else begin
                cnt_j <= '0;
                if (!i_last) begin
                  cnt_i <= cnt_i + dim_one;
                end else begin
                  cnt_i <= '0;
                  state <= tensor_product_pkg::load_b;
                end
              end
            end
          end
        end
        // B walks l, then k
        tensor_product_pkg::load_b: begin
          if (data_b_enable) begin
            if (!l_last) begin
              cnt_l <= cnt_l + dim_one;
            end else begin
              cnt_l <= '0;
              if (!k_last) begin
                cnt_k <= cnt_k + dim_one;
              end else begin
                cnt_k <= '0;
                state <= tensor_product_pkg::multiply;
              end
            end
          end
        end
        tensor_product_pkg::multiply: begin
          if (mul.ready) begin
            mul_wait <= 1'b0;
            state    <= tensor_product_pkg::accumulate;
          end else begin
            mul_wait <= 1'b1;
          end
        end
        // Last k step hands the sum straight to the output register
        tensor_product_pkg::accumulate: begin
          if (add.ready) begin
            add_wait <= 1'b0;
            acc      <= add.result;
            if (k_last) begin
              data_out        <= add.result;
              data_out_enable <= 1'b1;
              data_out_last   <= i_last && j_last && l_last;
              state           <= tensor_product_pkg::emit;
            end else begin
              cnt_k <= cnt_k + dim_one;
              state <= tensor_product_pkg::multiply;
            end
          end else begin
            add_wait <= 1'b1;
          end
        end
        // Output beat on the bus this cycle
        tensor_product_pkg::emit: begin
          acc   <= '0;
          cnt_k <= '0;
          if (data_out_last) begin
            ready <= 1'b1;
            state <= tensor_product_pkg::idle;
          end else begin
            state <= tensor_product_pkg::advance;
          end
        end
        // Next C element, l fastest then j then i
        tensor_product_pkg::advance: begin
          if (!l_last) begin
            cnt_l <= cnt_l + dim_one;
          end else begin
            cnt_l <= '0;
            if (!j_last) begin
              cnt_j <= cnt_j + dim_one;
            end else begin
              cnt_j <= '0;
              cnt_i <= cnt_i + dim_one;
            end
          end
          state <= tensor_product_pkg::multiply;
        end
        default: begin
          state <= tensor_product_pkg::idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Result lands one cycle after start, no new request before that
  assert property (@(posedge CLK) disable iff (RST) mul.start |=> !mul.start);
  assert property (@(posedge CLK) disable iff (RST) add.start |=> !add.start);

  assert property (@(posedge CLK) disable iff (RST)
    data_out_enable |-> state == tensor_product_pkg::emit);

endmodule

// File: tensor_product_config.svh
/* Sizes for the tensor-matrix product
   Each of I, J, K and L must lie in 1..TMP_MAX_DIM
   TMP_DIM_WIDTH must hold TMP_MAX_DIM itself, not only its highest index */
`ifndef TENSOR_PRODUCT_CONFIG_SVH
`define TENSOR_PRODUCT_CONFIG_SVH

// Element width of A, B and C, two's complement
`define TMP_DATA_WIDTH 16

// Largest size on any axis
`define TMP_MAX_DIM 4

// Size and index width
`define TMP_DIM_WIDTH 3

`endif

// File: tensor_product_pkg.sv
/* Shared types for the tensor-matrix product
   Widths come from the config header */
`include "tensor_product_config.svh"

package tensor_product_pkg;

  // One signed element of A, B or C
  typedef logic signed [`TMP_DATA_WIDTH-1:0] data_t;

  // One size or loop index
  typedef logic [`TMP_DIM_WIDTH-1:0] dim_t;

  // Controller FSM
  typedef enum logic [2:0] {
    idle,
    load_a,
    load_b,
    multiply,
    accumulate,
    emit,
    advance
  } tmp_state_t;

endpackage

// File: tensor_product_top.sv
/* Tensor-matrix product subsystem with plain ports
   Same handshake and stream rules as the controller
   One multiplier and one adder, used in turn for each k step */
`timescale 1ns/100ps

module tensor_product_top (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      start,
  output logic                      ready,
  input  tensor_product_pkg::dim_t  size_i,
  input  tensor_product_pkg::dim_t  size_j,
  input  tensor_product_pkg::dim_t  size_k,
  input  tensor_product_pkg::dim_t  size_l,
  input  tensor_product_pkg::data_t data_a_in,
  input  logic                      data_a_enable,
  input  tensor_product_pkg::data_t data_b_in,
  input  logic                      data_b_enable,
  output tensor_product_pkg::data_t data_out,
  output logic                      data_out_enable,
  output logic                      data_out_last
);

  // Links to the two scalar units
  scalar_op_if mul_bus ();
  scalar_op_if add_bus ();

  tensor_matrix_product controller_i (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .ready          (ready),
    .size_i         (size_i),
    .size_j         (size_j),
    .size_k         (size_k),
    .size_l         (size_l),
    .data_a_in      (data_a_in),
    .data_a_enable  (data_a_enable),
    .data_b_in      (data_b_in),
    .data_b_enable  (data_b_enable),
    .data_out       (data_out),
    .data_out_enable(data_out_enable),
    .data_out_last  (data_out_last),
    .mul            (mul_bus.controller),
    .add            (add_bus.controller)
  );

  scalar_int_multiplier multiplier_i (
    .CLK(CLK),
    .RST(RST),
    .bus(mul_bus.unit)
  );

  scalar_int_adder adder_i (
    .CLK(CLK),
    .RST(RST),
    .bus(add_bus.unit)
  );

endmodule
